// File: filelist.f
+incdir+include
hw/mem_pkg.sv
hw/stall_gen.sv
hw/fetch_port.sv
hw/load_store_port.sv
hw/unified_mem_array.sv
hw/unified_mem_top.sv
tb/unified_mem_properties.sv
tb/unified_mem_tb.sv

// File: tb/unified_mem_trace.hex
// sel (0 load/store, 1 fetch, f ends the trace)  we  mask  byte address  wdata  expected rdata
// expected rdata is zero for every write, dmem_rd stays zero on a store
// full words
0 1 f 00000000 11223344 00000000
0 1 f 00000004 a5a55a5a 00000000
0 1 f 00000008 deadbeef 00000000
0 1 f 0000000c 01234567 00000000
0 1 f 00000100 cafef00d 00000000
0 1 f 0000fffc 89abcdef 00000000
0 0 0 00000000 00000000 11223344
0 0 0 00000004 00000000 a5a55a5a
0 0 0 00000008 00000000 deadbeef
0 0 0 0000000c 00000000 01234567
0 0 0 00000100 00000000 cafef00d
0 0 0 0000fffc 00000000 89abcdef
// index 16384 wraps to word 0
0 0 0 00010000 00000000 11223344
// byte masked writes
0 1 1 00000008 000000ff 00000000
0 0 0 00000008 00000000 deadbeff
0 1 6 00000008 12345678 00000000
0 0 0 00000008 00000000 de3456ff
0 1 8 0000000c 99000000 00000000
0 0 0 0000000c 00000000 99234567
0 1 5 00000004 11223344 00000000
0 0 0 00000004 00000000 a5225a44
0 1 0 00000000 ffffffff 00000000
0 0 0 00000000 00000000 11223344
// same words seen from the fetch side
1 0 0 00000000 00000000 11223344
1 0 0 00000004 00000000 a5225a44
1 0 0 00000008 00000000 de3456ff
1 0 0 0000000c 00000000 99234567
1 0 0 00000100 00000000 cafef00d
1 0 0 0000fffc 00000000 89abcdef
// more writes, each must land exactly once
0 1 f 00000020 0f0f0f0f 00000000
0 1 3 00000020 0000aaaa 00000000
0 0 0 00000020 00000000 0f0faaaa
0 1 f 00000024 76543210 00000000
0 1 2 00000024 0000ff00 00000000
0 0 0 00000024 00000000 7654ff10
1 0 0 00000024 00000000 7654ff10
// byte offsets return the aligned word
0 0 0 00000009 00000000 de3456ff
0 0 0 0000000e 00000000 99234567
0 0 0 00000023 00000000 0f0faaaa
1 0 0 00000102 00000000 cafef00d
1 0 0 00000007 00000000 a5225a44
f 0 0 00000000 00000000 00000000

// File: tb/unified_mem_tb.sv
/* Trace driven testbench for unified_mem_top, stalls enabled on both ports.
   Trace is read from tb/unified_mem_trace.hex, six columns per access, sel f ends it. */
`timescale 1ns/1ps
`include "mem_defines.svh"

module unified_mem_tb;
	import mem_pkg::*;

	localparam int CLK_HALF = 10;
	localparam int RST_CYCLES = 5;
	localparam int TRACE_MAX = 64;
	localparam int COLS = 6;
	// worst case per access is a few stall cycles plus three idle cycles
	localparam int CYCLES_PER_ACCESS = 16;

	logic Bus;
	logic rst;
	logic imem_req;
	word_t imem_addr;
	word_t imem_instn;
	logic imem_wait;
	logic dmem_req;
	logic dmem_we;
	word_t dmem_addr;
	word_t dmem_wd;
	logic [3:0] dmem_mask;
	word_t dmem_rd;
	logic dmem_wait;

	// sel, we, mask, address, write data, expected read data
	logic [31:0] trace_mem [0:TRACE_MAX*COLS-1];
	int trace_len;
	int cycle_count = 0;
	int cycle_limit = 0;
	int stall_cycles = 0;

	unified_mem_top #(
		.DEPTH_WORDS(`MEM_DEPTH_WORDS),
		.STALL_EN(1'b1)
	) u_dut (
		.Bus(Bus),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_instn(imem_instn),
		.imem_wait(imem_wait),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wd(dmem_wd),
		.dmem_mask(dmem_mask),
		.dmem_rd(dmem_rd),
		.dmem_wait(dmem_wait)
	);

	always #CLK_HALF Bus = ~Bus;

	// run limit, set once the trace length is known
	always @(posedge Bus) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the trace did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$fatal(1, "run stopped at the cycle limit");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// both ports quiet, addresses parked on word 0
	task automatic drive_idle();
		imem_req = 1'b0;
		imem_addr = '0;
		dmem_req = 1'b0;
		dmem_we = 1'b0;
		dmem_addr = '0;
		dmem_wd = '0;
		dmem_mask = '0;
	endtask

	task automatic run_access(input int n);
		int base;
		int idle;
		logic fetch_sel;
		word_t exp;
		base = n * COLS;
		fetch_sel = (trace_mem[base][3:0] == 4'h1);
		exp = trace_mem[base+5];
		@(negedge Bus);
		// one port per line, the other one is dropped
		if (fetch_sel) begin
			imem_req = 1'b1;
			imem_addr = trace_mem[base+3];
			dmem_req = 1'b0;
			dmem_we = 1'b0;
		end else begin
			imem_req = 1'b0;
			dmem_req = 1'b1;
			dmem_we = trace_mem[base+1][0];
			dmem_mask = trace_mem[base+2][3:0];
			dmem_addr = trace_mem[base+3];
			dmem_wd = trace_mem[base+4];
		end
		#1;
		// hold the request through any miss cycles
		while (fetch_sel ? imem_wait : dmem_wait) begin
			stall_cycles++;
			@(negedge Bus);
			#1;
		end
		// completing cycle, data stays valid up to the rising edge
		if (fetch_sel) begin
			check_value("imem_instn", imem_instn, exp);
		end else begin
			check_value("dmem_rd", dmem_rd, exp);
		end
		// zero to three idle cycles before the next line
		idle = $urandom % 4;
		if (idle > 0) begin
			@(negedge Bus);
			drive_idle();
			repeat (idle - 1) @(negedge Bus);
		end
	endtask

	initial begin
		Bus = 1'b0;
		rst = 1'b1;
		drive_idle();
		void'($urandom(32'he3ef));
		$readmemh("tb/unified_mem_trace.hex", trace_mem);
		trace_len = 0;
		while (trace_len < TRACE_MAX && trace_mem[trace_len*COLS] !== 32'hF) begin
			trace_len++;
		end
		if (trace_len == 0 || trace_len == TRACE_MAX) begin
			$display("the trace file holds no accesses or lacks its end line");
			$display("TEST RESULT: FAIL");
			$fatal(1, "unusable trace");
		end
		cycle_limit = trace_len * CYCLES_PER_ACCESS + RST_CYCLES;
		repeat (RST_CYCLES) @(posedge Bus);
		@(negedge Bus);
		rst = 1'b0;
		for (int i = 0; i < trace_len; i++) begin
			run_access(i);
		end
		@(negedge Bus);
		drive_idle();
		repeat (2) @(negedge Bus);
		$display("%0d accesses, %0d stall cycles", trace_len, stall_cycles);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: tb/unified_mem_properties.sv
/* Handshake assertions for unified_mem_top, attached with bind.
   Read data checks are disabled while rst is high. */
`timescale 1ns/1ps

module unified_mem_properties (
	input logic Bus,
	input logic rst,
	input logic imem_req,
	input logic imem_wait,
	input mem_pkg::word_t imem_instn,
	input logic dmem_req,
	input logic dmem_wait,
	input mem_pkg::word_t dmem_rd
);

	// both waits are cleared by reset and still low one cycle past it
	a_wait_low_after_rst: assert property (
		@(posedge Bus) rst |=> (!imem_wait && !dmem_wait)
	) else $error("wait output high in the cycle after reset");

	// no fetch, no instruction word
	a_instn_zero_idle: assert property (
		@(posedge Bus) disable iff (rst)
		!imem_req |-> (imem_instn == '0)
	) else $error("imem_instn nonzero without a fetch request");

	// load data only in a completing cycle
	a_rd_zero_idle: assert property (
		@(posedge Bus) disable iff (rst)
		(!dmem_req || dmem_wait) |-> (dmem_rd == '0)
	) else $error("dmem_rd nonzero while idle or stalled");

	// a fetch held during a miss returns no instruction word
	a_instn_zero_stall: assert property (
		@(posedge Bus) disable iff (rst)
		imem_wait |-> (imem_instn == '0)
	) else $error("imem_instn nonzero while imem_wait is high");

endmodule

bind unified_mem_top unified_mem_properties u_props (
	.Bus(Bus),
	.rst(rst),
	.imem_req(imem_req),
	.imem_wait(imem_wait),
	.imem_instn(imem_instn),
	.dmem_req(dmem_req),
	.dmem_wait(dmem_wait),
	.dmem_rd(dmem_rd)
);

// File: hw/unified_mem_top.sv
/* Unified instruction and data memory with two side-by-side request ports.
   Each port has its own repeatable wait; a request completes when req is high and wait low. */
`timescale 1ns/1ps

module unified_mem_top #(
	parameter int unsigned DEPTH_WORDS = mem_pkg::DEF_DEPTH_WORDS,
	parameter bit STALL_EN = 1'b1,
	parameter logic [mem_pkg::STALL_LFSR_W-1:0] IMEM_SEED = mem_pkg::STALL_SEED_DEF,
	parameter logic [mem_pkg::STALL_LFSR_W-1:0] DMEM_SEED = 8'hC3
) (
	input logic Bus,
	input logic rst,
	// instruction side
	input logic imem_req,
	input mem_pkg::word_t imem_addr,
	output mem_pkg::word_t imem_instn,
	output logic imem_wait,
	// data side
	input logic dmem_req,
	input logic dmem_we,
	input mem_pkg::word_t dmem_addr,
	input mem_pkg::word_t dmem_wd,
	input logic [3:0] dmem_mask,
	output mem_pkg::word_t dmem_rd,
	output logic dmem_wait
);
	import mem_pkg::*;

	fetch_req_s fetch_req;
	ls_req_s ls_req;
	word_t fetch_word;
	word_t ls_word;

	fetch_port #(
		.STALL_EN(STALL_EN),
		.STALL_SEED(IMEM_SEED)
	) u_fetch (
		.Bus(Bus),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_wait(imem_wait),
		.fetch_req(fetch_req),
		.fetch_word(fetch_word),
		.imem_instn(imem_instn)
	);

	load_store_port #(
		.STALL_EN(STALL_EN),
		.STALL_SEED(DMEM_SEED)
	) u_ls (
		.Bus(Bus),
		.rst(rst),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wd(dmem_wd),
		.dmem_mask(dmem_mask),
		.dmem_wait(dmem_wait),
		.ls_req(ls_req),
		.ls_word(ls_word),
		.dmem_rd(dmem_rd)
	);

	// the one store behind both ports
	unified_mem_array #(
		.DEPTH_WORDS(DEPTH_WORDS)
	) u_array (
		.Bus(Bus),
		.fetch_req(fetch_req),
		.ls_req(ls_req),
		.fetch_word(fetch_word),
		.ls_word(ls_word)
	);

endmodule

// File: hw/unified_mem_array.sv
/* One word store shared by fetch and load/store, asynchronous read on both ports.
   DEPTH_WORDS must be a power of two; index bits above it wrap. No reset on the store. */
`timescale 1ns/1ps

module unified_mem_array #(
	parameter int unsigned DEPTH_WORDS = mem_pkg::DEF_DEPTH_WORDS
) (
	input logic Bus,
	input mem_pkg::fetch_req_s fetch_req,
	input mem_pkg::ls_req_s ls_req,
	output mem_pkg::word_t fetch_word,
	output mem_pkg::word_t ls_word
);
	import mem_pkg::*;

	// bits of the word index actually used by the store
	localparam int unsigned STORE_AW = $clog2(DEPTH_WORDS);

	word_t mem [DEPTH_WORDS];

	logic [STORE_AW-1:0] f_idx;
	logic [STORE_AW-1:0] l_idx;
	logic wr_en;

	// wrap modulo depth by keeping the low index bits
	assign f_idx = fetch_req.idx[STORE_AW-1:0];
	assign l_idx = ls_req.idx[STORE_AW-1:0];

	// ports have already folded stall into go
	assign wr_en = ls_req.go & ls_req.we;

	// reads are combinational from the array
	// the ports zero these outside a completing cycle
	// same-word fetch during a write sees the old word
	// since the write lands at the edge
	assign fetch_word = mem[f_idx];
	assign ls_word = mem[l_idx];

	// byte-masked write, each enabled lane of the union
	// goes to its own byte of the word
	always_ff @(posedge Bus) begin
		if (wr_en) begin
			for (int b = 0; b < LANES; b++) begin
				if (ls_req.mask[b]) begin
					mem[l_idx][8*b +: 8] <= ls_req.wdata.lanes[b];
				end
			end
		end
	end

endmodule

// File: hw/load_store_port.sv
/* Data side of the unified memory. Loads return the aligned word, stores write under
   dmem_mask at the edge ending the completing cycle; a store returns zero read data. */
`timescale 1ns/1ps

module load_store_port #(
	parameter bit STALL_EN = 1'b1,
	parameter logic [mem_pkg::STALL_LFSR_W-1:0] STALL_SEED = mem_pkg::STALL_SEED_DEF
) (
	input logic Bus,
	input logic rst,
	input logic dmem_req,
	input logic dmem_we,
	input mem_pkg::word_t dmem_addr,
	input mem_pkg::word_t dmem_wd,
	input logic [3:0] dmem_mask,
	output logic dmem_wait,
	output mem_pkg::ls_req_s ls_req,
	input mem_pkg::word_t ls_word,
	output mem_pkg::word_t dmem_rd
);
	import mem_pkg::*;

	logic ls_go;
	logic ls_load;
	byte_lanes_u wr_lanes;

	// separate LFSR from the fetch side, different seed
	stall_gen #(
		.STALL_EN(STALL_EN),
		.STALL_SEED(STALL_SEED)
	) u_stall (
		.Bus(Bus),
		.rst(rst),
		.stall(dmem_wait)
	);

	// the only place the stall is applied
	// the array acts on go without looking at wait
	assign ls_go = dmem_req & ~dmem_wait;

	// completing read, the store's word is returned only here
	assign ls_load = ls_go & ~dmem_we;

	// write data goes in as a whole word
	// the array takes it apart lane by lane
	assign wr_lanes.word = dmem_wd;

	always_comb begin
		ls_req.go = ls_go;
		ls_req.we = dmem_we;
		// loads carry no mask so no lane can be enabled on a read
		ls_req.mask = dmem_we ? dmem_mask : '0;
		// low two bits ignored, misaligned accesses hit the aligned word
		ls_req.idx = dmem_addr[ADDR_W-1:OFFS_W];
		ls_req.wdata = wr_lanes;
	end

	// zero when idle, stalled or writing
	assign dmem_rd = ls_load ? ls_word : '0;

endmodule

// File: hw/fetch_port.sv
/* Instruction side of the unified memory. A fetch completes when imem_req is high and
   imem_wait is low; the low two address bits are ignored. */
`timescale 1ns/1ps

module fetch_port #(
	parameter bit STALL_EN = 1'b1,
	parameter logic [mem_pkg::STALL_LFSR_W-1:0] STALL_SEED = mem_pkg::STALL_SEED_DEF
) (
	input logic Bus,
	input logic rst,
	input logic imem_req,
	input mem_pkg::word_t imem_addr,
	output logic imem_wait,
	output mem_pkg::fetch_req_s fetch_req,
	input mem_pkg::word_t fetch_word,
	output mem_pkg::word_t imem_instn
);
	import mem_pkg::*;

	logic fetch_go;

	// this port's own miss model
	stall_gen #(
		.STALL_EN(STALL_EN),
		.STALL_SEED(STALL_SEED)
	) u_stall (
		.Bus(Bus),
		.rst(rst),
		.stall(imem_wait)
	);

	// a fetch only goes to the store in its completing cycle
	// while stalled the core holds its address and we hold go low
	assign fetch_go = imem_req & ~imem_wait;

	always_comb begin
		fetch_req.go = fetch_go;
		// byte offset dropped, word index only
		fetch_req.idx = imem_addr[ADDR_W-1:OFFS_W];
	end

	// instruction is zero unless the fetch completes this cycle
	assign imem_instn = fetch_go ? fetch_word : '0;

endmodule

// File: hw/stall_gen.sv
/* Repeatable L1 miss model for one port: an 8-bit galois LFSR stepped every Bus edge.
   STALL_SEED must be nonzero with its low three bits not all ones. */
`timescale 1ns/1ps

module stall_gen #(
	parameter bit STALL_EN = 1'b1,
	parameter logic [mem_pkg::STALL_LFSR_W-1:0] STALL_SEED = mem_pkg::STALL_SEED_DEF
) (
	input logic Bus,
	input logic rst,
	output logic stall
);
	import mem_pkg::*;

	logic [STALL_LFSR_W-1:0] lfsr;
	logic [STALL_LFSR_W-1:0] lfsr_next;

	// one galois step, feedback taps applied when the shifted-out bit is set
	always_comb begin
		lfsr_next = lfsr >> 1;
		if (lfsr[0]) begin
			lfsr_next = lfsr_next ^ STALL_TAP_MASK;
		end
	end

	// stall is registered alongside the LFSR so it always matches the
	// current state's low bits, and it stays low through reset
	always_ff @(posedge Bus) begin
		if (rst) begin
			lfsr <= STALL_SEED;
			stall <= 1'b0;
		end else begin
			lfsr <= lfsr_next;
			// miss when the low bits of the new state are all ones
			stall <= STALL_EN && (&lfsr_next[STALL_HIT_BITS-1:0]);
		end
	end

endmodule

// File: hw/mem_pkg.sv
/* Shared types and constants for the unified instruction and data memory.
   Byte lanes are little endian, lane 0 is bits 7:0. The stall LFSR is 8 bits wide. */
`include "mem_defines.svh"

package mem_pkg;

	// byte address split into word index and byte offset
	localparam int unsigned ADDR_W = `MEM_ADDR_W;
	localparam int unsigned OFFS_W = 2;
	localparam int unsigned IDX_W = ADDR_W - OFFS_W;
	localparam int unsigned LANES = 4;
	localparam int unsigned DEF_DEPTH_WORDS = `MEM_DEPTH_WORDS;

	// miss model constants
	localparam int unsigned STALL_LFSR_W = 8;
	// wait fires when this many low LFSR bits are all ones, about 1 in 8
	localparam int unsigned STALL_HIT_BITS = 3;
	// x^8 + x^6 + x^5 + x^4 + 1 in right-shift galois form, maximal length
	localparam logic [STALL_LFSR_W-1:0] STALL_TAP_MASK = 8'hB8;
	// nonzero and low three bits not all ones, so no wait right after reset
	localparam logic [STALL_LFSR_W-1:0] STALL_SEED_DEF = 8'h5A;

	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;

	// write data seen as a whole word by the port
	// and as four lanes by the store
	typedef union packed {
		word_t word;
		byte_t [LANES-1:0] lanes;
	} byte_lanes_u;

	// fetch side request into the store
	typedef struct packed {
		logic go;
		logic [IDX_W-1:0] idx;
	} fetch_req_s;

	// load/store side request into the store
	// mask is zero unless we is set
	typedef struct packed {
		logic go;
		logic we;
		logic [LANES-1:0] mask;
		logic [IDX_W-1:0] idx;
		byte_lanes_u wdata;
	} ls_req_s;

endpackage

// File: include/mem_defines.svh
/* Defaults for the unified memory, shared by the package and the testbench.
   MEM_DEPTH_WORDS must be a power of two because the store index wraps on its low bits. */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address width seen by the core
// addresses travel as 32-bit words, so keep this at 32 or below
`define MEM_ADDR_W 32

// store depth in 32-bit words
// 16384 words is 64 KB
`define MEM_DEPTH_WORDS 16384

`endif
